// ==== source/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Datapath widths
`define MEM_WORD_BITS      32
`define MEM_REG_ADDR_BITS  5
`define MEM_BYTES_PER_WORD (`MEM_WORD_BITS / 8)

// Data cache geometry, one bank per word of a line
`define MEM_SETS           16
`define MEM_LINE_WORDS     4
`define MEM_INDEX_BITS     $clog2(`MEM_SETS)
`define MEM_OFFSET_BITS    $clog2(`MEM_LINE_WORDS)
`define MEM_BYTE_BITS      $clog2(`MEM_BYTES_PER_WORD)
`define MEM_WADDR_BITS     (`MEM_WORD_BITS - `MEM_BYTE_BITS)

// Store buffer
`define MEM_SB_DEPTH       4
`define MEM_SB_PTR_BITS    $clog2(`MEM_SB_DEPTH)
`define MEM_SB_CNT_BITS    ($clog2(`MEM_SB_DEPTH) + 1)

`endif

// ==== source/mem_pkg.sv ====
`include "mem_params.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } memop_size_e;

    // Write command for one word bank
    typedef struct packed {
        logic [`MEM_INDEX_BITS-1:0]     index;
        logic [`MEM_BYTES_PER_WORD-1:0] be;
        logic [`MEM_WORD_BITS-1:0]      data;
    } bank_wr_t;

    typedef struct packed {
        logic [`MEM_WADDR_BITS-1:0]     waddr;
        logic [`MEM_BYTES_PER_WORD-1:0] mask;
        logic [`MEM_WORD_BITS-1:0]      data;
    } sb_entry_t;

    // From execute, addr doubles as the ALU result
    typedef struct packed {
        logic [`MEM_WORD_BITS-1:0]     addr;
        logic                          ld;
        logic                          st;
        memop_size_e                   size;
        logic                          sign_ext;
        logic [`MEM_WORD_BITS-1:0]     st_data;
        logic                          rf_we;
        logic [`MEM_REG_ADDR_BITS-1:0] rf_waddr;
        logic                          tkbr;
        logic [`MEM_WORD_BITS-1:0]     new_pc;
    } ex_mem_t;

    typedef struct packed {
        logic [`MEM_WORD_BITS-1:0]     res;
        logic                          rf_we;
        logic [`MEM_REG_ADDR_BITS-1:0] rf_waddr;
        logic                          tkbr;
        logic [`MEM_WORD_BITS-1:0]     new_pc;
    } mem_wb_t;

endpackage

// ==== source/dcache_write_steer.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module dcache_write_steer (
    input  logic                                             mmu_refill_i,
    input  logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0]   mmu_line_i,
    input  logic [`MEM_INDEX_BITS-1:0]                      mmu_victim_index_i,
    input  logic                                             drain_valid_i,
    input  mem_pkg::sb_entry_t                               drain_entry_i,
    output mem_pkg::bank_wr_t [`MEM_LINE_WORDS-1:0]          bank_wr_o
);

    logic [`MEM_INDEX_BITS-1:0]  drain_index;
    logic [`MEM_OFFSET_BITS-1:0] drain_bank;

    // Word address splits into set index and bank select
    assign drain_bank  = drain_entry_i.waddr[`MEM_OFFSET_BITS-1:0];
    assign drain_index = drain_entry_i.waddr[`MEM_OFFSET_BITS +: `MEM_INDEX_BITS];

    always_comb begin
        for (int b = 0; b < `MEM_LINE_WORDS; b++) begin
            if (mmu_refill_i) begin
                // Whole line at the victim set
                bank_wr_o[b].index = mmu_victim_index_i;
                bank_wr_o[b].be    = '1;
                bank_wr_o[b].data  = mmu_line_i[b];
            end else begin
                bank_wr_o[b].index = drain_index;
                bank_wr_o[b].data  = drain_entry_i.data;
                if (drain_valid_i && (b == drain_bank)) begin
                    bank_wr_o[b].be = drain_entry_i.mask;
                end else begin
                    bank_wr_o[b].be = '0;
                end
            end
        end
    end

endmodule

// ==== source/dcache_bank.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module dcache_bank (
    input  logic                       clk_i,
    input  mem_pkg::bank_wr_t          bank_wr_i,
    input  logic [`MEM_INDEX_BITS-1:0] rd_index_i,
    output logic [`MEM_WORD_BITS-1:0]  rd_word_o
);

    // One word per set
    logic [`MEM_WORD_BITS-1:0] mem [`MEM_SETS];

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < `MEM_BYTES_PER_WORD; b++) begin
            if (bank_wr_i.be[b]) begin
                mem[bank_wr_i.index][8*b +: 8] <= bank_wr_i.data[8*b +: 8];
            end
        end
    end

    // Asynchronous read
    assign rd_word_o = mem[rd_index_i];

endmodule

// ==== source/dcache_read_select.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module dcache_read_select (
    input  logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0] bank_words_i,
    input  logic [`MEM_OFFSET_BITS-1:0]                   word_offset_i,
    output logic [`MEM_WORD_BITS-1:0]                     load_word_o,
    output logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0] victim_line_o
);

    // Word named by the load offset
    always_comb begin
        load_word_o = '0;
        for (int b = 0; b < `MEM_LINE_WORDS; b++) begin
            if (word_offset_i == b) begin
                load_word_o = bank_words_i[b];
            end
        end
    end

    // Bank 0 lands in the low word of the line
    always_comb begin
        for (int b = 0; b < `MEM_LINE_WORDS; b++) begin
            victim_line_o[b] = bank_words_i[b];
        end
    end

endmodule

// ==== source/store_buffer.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module store_buffer (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              st_valid_i,
    input  logic [`MEM_WORD_BITS-1:0]         st_addr_i,
    input  mem_pkg::memop_size_e              st_size_i,
    input  logic [`MEM_WORD_BITS-1:0]         st_data_i,
    input  logic [`MEM_WORD_BITS-1:0]         ld_addr_i,
    output logic [`MEM_WORD_BITS-1:0]         fwd_data_o,
    output logic [`MEM_BYTES_PER_WORD-1:0]    fwd_mask_o,
    input  logic                              drain_en_i,
    output logic                              drain_valid_o,
    output mem_pkg::sb_entry_t                drain_entry_o,
    output logic                              sb_full_o
);

    mem_pkg::sb_entry_t             q [`MEM_SB_DEPTH];
    logic [`MEM_SB_CNT_BITS-1:0]    count;
    logic [`MEM_BYTE_BITS-1:0]      st_off;
    logic [`MEM_WADDR_BITS-1:0]     st_waddr;
    logic [`MEM_WADDR_BITS-1:0]     ld_waddr;
    logic [`MEM_BYTES_PER_WORD-1:0] st_mask;
    logic [`MEM_WORD_BITS-1:0]      st_word;
    logic                           hit_any;
    logic [`MEM_SB_PTR_BITS-1:0]    hit_idx;
    mem_pkg::sb_entry_t             merged;

    assign st_off   = st_addr_i[`MEM_BYTE_BITS-1:0];
    assign st_waddr = st_addr_i[`MEM_WORD_BITS-1:`MEM_BYTE_BITS];
    assign ld_waddr = ld_addr_i[`MEM_WORD_BITS-1:`MEM_BYTE_BITS];

    // Align store to its byte lanes
    always_comb begin
        unique case (st_size_i)
            mem_pkg::BYTE: st_mask = 4'b0001 << st_off;
            mem_pkg::HALF: st_mask = 4'b0011 << st_off;
            default:       st_mask = 4'b1111;
        endcase
        st_word = st_data_i << {st_off, 3'b000};
    end

    // Entry with the same word, unique thanks to merging
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `MEM_SB_DEPTH; i++) begin
            if ((i < count) && (q[i].waddr == st_waddr)) begin
                hit_any = 1'b1;
                hit_idx = i[`MEM_SB_PTR_BITS-1:0];
            end
        end
        merged      = q[hit_idx];
        merged.mask = q[hit_idx].mask | st_mask;
        for (int b = 0; b < `MEM_BYTES_PER_WORD; b++) begin
            if (st_mask[b]) begin
                merged.data[8*b +: 8] = st_word[8*b +: 8];
            end
        end
    end

    always_comb begin
        fwd_mask_o = '0;
        fwd_data_o = '0;
        for (int i = 0; i < `MEM_SB_DEPTH; i++) begin
            if ((i < count) && (q[i].waddr == ld_waddr)) begin
                fwd_mask_o = fwd_mask_o | q[i].mask;
                fwd_data_o = q[i].data;
            end
        end
    end

    // Oldest entry sits at slot 0
    always_ff @(posedge clk_i) begin
        if (drain_en_i) begin
            for (int i = 0; i < `MEM_SB_DEPTH - 1; i++) begin
                q[i] <= q[i+1];
            end
        end else if (st_valid_i) begin
            if (hit_any) begin
                q[hit_idx] <= merged;
            end else if (!sb_full_o) begin
                q[count[`MEM_SB_PTR_BITS-1:0]] <= '{waddr: st_waddr, mask: st_mask, data: st_word};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else if (drain_en_i && drain_valid_o) begin
            count <= count - 1'b1;
        end else if (st_valid_i && !hit_any && !sb_full_o) begin
            count <= count + 1'b1;
        end
    end

    assign drain_valid_o = (count != '0);
    assign drain_entry_o = q[0];
    assign sb_full_o     = (count == `MEM_SB_DEPTH);

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module mem_stage (
    input  logic                                             clk_i,
    input  logic                                             rst_n_i,
    input  mem_pkg::ex_mem_t                                 ex_mem_i,
    input  logic                                             mmu_refill_i,
    input  logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0]   mmu_line_i,
    input  logic [`MEM_INDEX_BITS-1:0]                      mmu_victim_index_i,
    output logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0]   victim_line_o,
    output logic                                             sb_full_o,
    output mem_pkg::mem_wb_t                                 mem_wb_o
);

    logic                                           drain_valid;
    logic                                           drain_en;
    mem_pkg::sb_entry_t                             drain_entry;
    mem_pkg::bank_wr_t [`MEM_LINE_WORDS-1:0]        bank_wr;
    logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0] bank_words;
    logic [`MEM_INDEX_BITS-1:0]                     rd_index;
    logic [`MEM_BYTE_BITS-1:0]                      byte_off;
    logic [`MEM_WORD_BITS-1:0]                      cache_word;
    logic [`MEM_WORD_BITS-1:0]                      fwd_data;
    logic [`MEM_BYTES_PER_WORD-1:0]                 fwd_mask;
    logic [`MEM_WORD_BITS-1:0]                      merged_word;
    logic [`MEM_WORD_BITS-1:0]                      shifted;
    logic [`MEM_WORD_BITS-1:0]                      load_res;

    assign byte_off = ex_mem_i.addr[`MEM_BYTE_BITS-1:0];

    // Array port is free only with no memop and no refill
    assign drain_en = drain_valid && !ex_mem_i.ld && !ex_mem_i.st && !mmu_refill_i;

    // Refill owns the read port, idle cycles look at the victim set too
    assign rd_index = (ex_mem_i.ld && !mmu_refill_i)
                    ? ex_mem_i.addr[`MEM_BYTE_BITS + `MEM_OFFSET_BITS +: `MEM_INDEX_BITS]
                    : mmu_victim_index_i;

    store_buffer u_store_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .st_valid_i    (ex_mem_i.st),
        .st_addr_i     (ex_mem_i.addr),
        .st_size_i     (ex_mem_i.size),
        .st_data_i     (ex_mem_i.st_data),
        .ld_addr_i     (ex_mem_i.addr),
        .fwd_data_o    (fwd_data),
        .fwd_mask_o    (fwd_mask),
        .drain_en_i    (drain_en),
        .drain_valid_o (drain_valid),
        .drain_entry_o (drain_entry),
        .sb_full_o     (sb_full_o)
    );

    dcache_write_steer u_write_steer (
        .mmu_refill_i       (mmu_refill_i),
        .mmu_line_i         (mmu_line_i),
        .mmu_victim_index_i (mmu_victim_index_i),
        .drain_valid_i      (drain_en),
        .drain_entry_i      (drain_entry),
        .bank_wr_o          (bank_wr)
    );

    for (genvar b = 0; b < `MEM_LINE_WORDS; b++) begin : g_bank
        dcache_bank u_bank (
            .clk_i      (clk_i),
            .bank_wr_i  (bank_wr[b]),
            .rd_index_i (rd_index),
            .rd_word_o  (bank_words[b])
        );
    end

    dcache_read_select u_read_select (
        .bank_words_i  (bank_words),
        .word_offset_i (ex_mem_i.addr[`MEM_BYTE_BITS +: `MEM_OFFSET_BITS]),
        .load_word_o   (cache_word),
        .victim_line_o (victim_line_o)
    );

    // Buffered bytes are newer than the array
    always_comb begin
        for (int b = 0; b < `MEM_BYTES_PER_WORD; b++) begin
            merged_word[8*b +: 8] = fwd_mask[b] ? fwd_data[8*b +: 8] : cache_word[8*b +: 8];
        end
    end

    assign shifted = merged_word >> {byte_off, 3'b000};

    always_comb begin
        unique case (ex_mem_i.size)
            mem_pkg::BYTE: begin
                load_res = {{24{ex_mem_i.sign_ext & shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::HALF: begin
                load_res = {{16{ex_mem_i.sign_ext & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_res = shifted;
            end
        endcase
    end

    // Control toward writeback
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_wb_o.rf_we <= 1'b0;
            mem_wb_o.tkbr  <= 1'b0;
        end else begin
            mem_wb_o.rf_we <= ex_mem_i.rf_we;
            mem_wb_o.tkbr  <= ex_mem_i.tkbr;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_wb_o.res      <= ex_mem_i.ld ? load_res : ex_mem_i.addr;
        mem_wb_o.rf_waddr <= ex_mem_i.rf_waddr;
        mem_wb_o.new_pc   <= ex_mem_i.new_pc;
    end

endmodule

// ==== tests/mem_stage_assertions.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module mem_stage_assertions (
    input logic             clk_i,
    input logic             rst_n_i,
    input mem_pkg::ex_mem_t ex_mem_i,
    input logic             st_hit_i,
    input logic             sb_full_i,
    input mem_pkg::mem_wb_t mem_wb_i
);

    int fail_count = 0;

    // A full buffer only takes stores that merge into an entry
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_mem_i.st && sb_full_i) |-> st_hit_i)
    else begin
        $error("store issued to a new word while the store buffer is full");
        fail_count++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rst_n_i |=> (mem_wb_i.rf_we == $past(ex_mem_i.rf_we))
                 && (mem_wb_i.rf_waddr == $past(ex_mem_i.rf_waddr))
                 && (mem_wb_i.tkbr == $past(ex_mem_i.tkbr))
                 && (mem_wb_i.new_pc == $past(ex_mem_i.new_pc)))
    else begin
        $error("pass-through fields do not follow execute by one cycle");
        fail_count++;
    end

    // Upper bits copy the sign bit or stay zero
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_mem_i.ld && ex_mem_i.size == mem_pkg::BYTE) |=>
        (mem_wb_i.res[31:8] == ($past(ex_mem_i.sign_ext) ? {24{mem_wb_i.res[7]}} : 24'd0)))
    else begin
        $error("byte load result is not correctly extended");
        fail_count++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_mem_i.ld && ex_mem_i.size == mem_pkg::HALF) |=>
        (mem_wb_i.res[31:16] == ($past(ex_mem_i.sign_ext) ? {16{mem_wb_i.res[15]}} : 16'd0)))
    else begin
        $error("halfword load result is not correctly extended");
        fail_count++;
    end

    assert property (@(posedge clk_i) !rst_n_i |=> !sb_full_i)
    else begin
        $error("store buffer reports full after reset");
        fail_count++;
    end

endmodule

bind mem_stage mem_stage_assertions u_mem_stage_assertions (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ex_mem_i  (ex_mem_i),
    .st_hit_i  (u_store_buffer.hit_any),
    .sb_full_i (sb_full_o),
    .mem_wb_i  (mem_wb_o)
);

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module tb_mem_stage;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 16;
    localparam int LW          = `MEM_LINE_WORDS;
    localparam int LINE_BYTES  = LW * `MEM_BYTES_PER_WORD;
    localparam int MEM_BYTES   = `MEM_SETS * LINE_BYTES;
    localparam int PT_OPS      = 8;
    localparam int LD_OPS      = 24;
    localparam int FWD_ROUNDS  = 6;
    localparam int VICT_ROUNDS = 3;
    // Cycles of all tests including flush cycles
    localparam int TOTAL_OPS   = PT_OPS + `MEM_SETS + LD_OPS + 4 * FWD_ROUNDS
                               + 5 * `MEM_SB_DEPTH + 10 + 6 * VICT_ROUNDS + 12;

    logic                              clk;
    logic                              rst_n;
    mem_pkg::ex_mem_t                  ex_mem;
    logic                              mmu_refill;
    logic [LW-1:0][`MEM_WORD_BITS-1:0] mmu_line;
    logic [`MEM_INDEX_BITS-1:0]        mmu_victim_index;
    logic [LW-1:0][`MEM_WORD_BITS-1:0] victim_line;
    logic                              sb_full;
    mem_pkg::mem_wb_t                  mem_wb;

    logic [7:0]       model_mem [MEM_BYTES];
    logic [31:0]      rng_state = 32'd60125;
    mem_pkg::mem_wb_t exp_next;
    mem_pkg::mem_wb_t chk_exp;
    logic             exp_next_valid = 1'b0;
    logic             chk_valid = 1'b0;
    string            cur_test = "reset";
    int               checks = 0;
    int               errors = 0;
    int               test_errors = 0;
    int               total_fail;

    mem_stage u_mem_stage (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .ex_mem_i           (ex_mem),
        .mmu_refill_i       (mmu_refill),
        .mmu_line_i         (mmu_line),
        .mmu_victim_index_i (mmu_victim_index),
        .victim_line_o      (victim_line),
        .sb_full_o          (sb_full),
        .mem_wb_o           (mem_wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic mem_pkg::memop_size_e rand_size();
        return mem_pkg::memop_size_e'(2'(next_random() % 3));
    endfunction

    // Aligned to the access size within the modelled range
    function automatic logic [31:0] rand_addr(input mem_pkg::memop_size_e sz);
        logic [31:0] a;
        a = next_random() % MEM_BYTES;
        if (sz == mem_pkg::HALF) a[0] = 1'b0;
        if (sz == mem_pkg::WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic mem_pkg::ex_mem_t make_op(input logic ld, input logic st,
            input logic [31:0] addr, input mem_pkg::memop_size_e sz, input logic [31:0] data);
        mem_pkg::ex_mem_t op;
        logic [31:0]      r;
        r           = next_random();
        op.addr     = addr;
        op.ld       = ld;
        op.st       = st;
        op.size     = sz;
        op.sign_ext = r[0];
        op.st_data  = data;
        op.rf_we    = r[1];
        op.rf_waddr = r[`MEM_REG_ADDR_BITS+1:2];
        op.tkbr     = r[7];
        op.new_pc   = next_random();
        return op;
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] addr,
            input mem_pkg::memop_size_e sz, input logic sign_ext);
        logic [31:0] v;
        int          n;
        v = '0;
        n = (sz == mem_pkg::BYTE) ? 1 : (sz == mem_pkg::HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) v[8*i +: 8] = model_mem[(addr + i) % MEM_BYTES];
        if (sign_ext && n < 4 && v[8*n-1]) begin
            for (int i = 8 * n; i < 32; i++) v[i] = 1'b1;
        end
        return v;
    endfunction

    always @(posedge clk) begin
        chk_valid <= exp_next_valid;
        chk_exp   <= exp_next;
    end

    // Writeback register is stable at the falling edge
    always @(negedge clk) begin
        if (chk_valid) begin
            checks++;
            assert (mem_wb === chk_exp) else begin
                $display("Error %s: expected %h, actual %h", cur_test, chk_exp, mem_wb);
                errors++;
            end
        end
    end

    task automatic issue(input mem_pkg::ex_mem_t op);
        mem_pkg::mem_wb_t exp;
        int               n;
        exp.res      = op.ld ? model_load(op.addr, op.size, op.sign_ext) : op.addr;
        exp.rf_we    = op.rf_we;
        exp.rf_waddr = op.rf_waddr;
        exp.tkbr     = op.tkbr;
        exp.new_pc   = op.new_pc;
        // Stores are visible at once through forwarding
        n = (op.size == mem_pkg::BYTE) ? 1 : (op.size == mem_pkg::HALF) ? 2 : 4;
        if (op.st) begin
            for (int i = 0; i < n; i++) begin
                model_mem[(op.addr + i) % MEM_BYTES] = op.st_data[8*i +: 8];
            end
        end
        @(posedge clk);
        ex_mem         <= op;
        mmu_refill     <= 1'b0;
        exp_next       <= exp;
        exp_next_valid <= 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            ex_mem         <= '0;
            mmu_refill     <= 1'b0;
            exp_next_valid <= 1'b0;
        end
    endtask

    task automatic refill(input logic [`MEM_INDEX_BITS-1:0] idx);
        logic [LW-1:0][`MEM_WORD_BITS-1:0] line;
        for (int w = 0; w < LW; w++) line[w] = next_random();
        @(posedge clk);
        ex_mem           <= '0;
        mmu_refill       <= 1'b1;
        mmu_line         <= line;
        mmu_victim_index <= idx;
        exp_next_valid   <= 1'b0;
        for (int w = 0; w < LW; w++) begin
            for (int b = 0; b < 4; b++) begin
                model_mem[idx * LINE_BYTES + 4 * w + b] = line[w][8*b +: 8];
            end
        end
    endtask

    task automatic check_full(input logic expected);
        @(negedge clk);
        checks++;
        assert (sb_full === expected) else begin
            $display("Error %s: sb_full_o expected %b, actual %b", cur_test, expected, sb_full);
            errors++;
        end
    endtask

    task automatic check_victim(input logic [`MEM_INDEX_BITS-1:0] idx);
        logic [LW-1:0][`MEM_WORD_BITS-1:0] exp;
        for (int w = 0; w < LW; w++) begin
            for (int b = 0; b < 4; b++) begin
                exp[w][8*b +: 8] = model_mem[idx * LINE_BYTES + 4 * w + b];
            end
        end
        @(negedge clk);
        checks++;
        assert (victim_line === exp) else begin
            $display("Error %s: victim line expected %h, actual %h", cur_test, exp, victim_line);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    // Two idle cycles let the last check complete first
    task automatic finish_test();
        idle(2);
        @(negedge clk);
        $display("%s done, %0d errors", cur_test, errors - test_errors);
    endtask

    initial begin
        logic [31:0]                a;
        logic [31:0]                r;
        mem_pkg::memop_size_e       sz;
        logic [`MEM_INDEX_BITS-1:0] idx;
        rst_n            = 1'b0;
        ex_mem           = '0;
        mmu_refill       = 1'b0;
        mmu_line         = '0;
        mmu_victim_index = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        start_test("pass_through");
        repeat (PT_OPS) issue(make_op(1'b0, 1'b0, next_random(), mem_pkg::WORD, '0));
        finish_test();

        start_test("refill_load");
        for (int s = 0; s < `MEM_SETS; s++) refill(s[`MEM_INDEX_BITS-1:0]);
        repeat (LD_OPS) begin
            sz = rand_size();
            issue(make_op(1'b1, 1'b0, rand_addr(sz), sz, '0));
        end
        finish_test();

        start_test("store_forward");
        repeat (FWD_ROUNDS) begin
            sz = rand_size();
            a  = rand_addr(sz);
            issue(make_op(1'b0, 1'b1, a, sz, next_random()));
            issue(make_op(1'b1, 1'b0, {a[31:2], 2'b00}, mem_pkg::WORD, '0));
            sz = rand_size();
            issue(make_op(1'b1, 1'b0, {a[31:2], 2'b00} | (rand_addr(sz) & 32'h3), sz, '0));
            idle(1);
        end
        finish_test();

        start_test("coalesce_full");
        idle(`MEM_SB_DEPTH + 1);
        a = (next_random() % (MEM_BYTES / 4 - `MEM_SB_DEPTH)) * 4;
        for (int k = 0; k < `MEM_SB_DEPTH; k++) begin
            issue(make_op(1'b0, 1'b1, a + 4 * k, mem_pkg::WORD, next_random()));
        end
        issue(make_op(1'b0, 1'b1, a + 2, mem_pkg::BYTE, next_random()));
        check_full(1'b1);
        for (int k = 0; k < `MEM_SB_DEPTH; k++) begin
            issue(make_op(1'b1, 1'b0, a + 4 * k, mem_pkg::WORD, '0));
        end
        check_full(1'b1);
        finish_test();

        start_test("drain");
        idle(`MEM_SB_DEPTH + 2);
        check_full(1'b0);
        for (int k = 0; k < `MEM_SB_DEPTH; k++) begin
            sz = rand_size();
            issue(make_op(1'b1, 1'b0, a + 4 * k + (rand_addr(sz) & 32'h3), sz, '0));
        end
        finish_test();

        start_test("victim_read");
        repeat (VICT_ROUNDS) begin
            r   = next_random() % `MEM_SETS;
            idx = r[`MEM_INDEX_BITS-1:0];
            refill(idx);
            a = idx * LINE_BYTES + 4 * (next_random() % LW);
            issue(make_op(1'b0, 1'b1, a, mem_pkg::WORD, next_random()));
            idle(3);
            check_victim(idx);
        end
        finish_test();

        total_fail = errors + u_mem_stage.u_mem_stage_assertions.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_mem_stage.u_mem_stage_assertions.fail_count);
        if (total_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #((TOTAL_OPS * 4 + RST_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/mem_pkg.sv
source/dcache_write_steer.sv
source/dcache_bank.sv
source/dcache_read_select.sv
source/store_buffer.sv
source/mem_stage.sv
tests/mem_stage_assertions.sv
tests/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/dcache_write_steer.sv
      - source/dcache_bank.sv
      - source/dcache_read_select.sv
      - source/store_buffer.sv
      - source/mem_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/mem_stage_assertions.sv
      - tests/tb_mem_stage.sv
